/* design/fall_pkg.sv */
// coordinate type, position and fall result structs, screen geometry constants for barrels
`default_nettype none

package fall_pkg;

    // one screen coordinate, same 11-bit space as the VGA timing
    typedef logic [10:0] coord_t;

    // top-left corner of an object on screen
    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    // one finished fall as handed to the game logic
    typedef struct packed {
        logic hit;     // barrel landed on the player
        pos_t end_pos; // where the barrel stopped
    } fall_result_t;

    localparam coord_t PLATFORM_Y = 11'd100;     // platform the enemy stands on
    localparam coord_t SPAWN_Y_OFFSET = 11'd64;  // barrel appears just below the platform
    localparam coord_t SPAWN_X_OFFSET = 11'd12;  // relative to the enemy's x
    localparam coord_t FLOOR_Y = 11'd736;        // a fall never goes past this line

    // start row of every barrel
    localparam coord_t START_Y = PLATFORM_Y + SPAWN_Y_OFFSET;

    // collision boxes
    localparam coord_t BARREL_W = 11'd32;
    localparam coord_t BARREL_H = 11'd40;
    localparam coord_t PLAYER_W = 11'd32;
    localparam coord_t PLAYER_H = 11'd40;

endpackage

`default_nettype wire

/* design/step_timer.sv */
// step_timer module, periodic single-cycle motion step while a fall runs
`default_nettype none

module step_timer #(
    parameter int unsigned STEP_PERIOD = 20000
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic step
);

    localparam int unsigned CNT_W = $clog2(STEP_PERIOD + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(STEP_PERIOD);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;                  // restart for the next fall
        end else if (count == CNT_LAST) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // gated by run so a stale count cannot fire as the fall ends
    assign step = run && (count == CNT_LAST);

endmodule

`default_nettype wire

/* design/barrel_motion.sv */
// barrel_motion module, barrel position and velocity with stepped gravity and floor clamp
`default_nettype none

module barrel_motion import fall_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   load,
    input  coord_t kong_x,
    input  logic   step,
    output pos_t   pos,
    output logic   at_floor
);

    coord_t      velocity;
    logic [11:0] y_sum;      // one extra bit so the sum cannot wrap past the floor
    coord_t      y_next;
    pos_t        start_pos;

    assign start_pos.x = kong_x + SPAWN_X_OFFSET;
    assign start_pos.y = START_Y;

    assign y_sum = {1'b0, pos.y} + {1'b0, velocity};

    always_comb begin
        if (y_sum >= {1'b0, FLOOR_Y}) begin
            y_next = FLOOR_Y;            // clamp at the floor line
        end else begin
            y_next = y_sum[10:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pos      <= '0;
            velocity <= '0;
        end else if (load) begin
            pos      <= start_pos;
            velocity <= '0;
        end else if (step) begin
            pos.y    <= y_next;          // x stays, barrels fall straight down
            velocity <= velocity + 1'b1;
        end
    end

    assign at_floor = (pos.y == FLOOR_Y);

endmodule

`default_nettype wire

/* design/hit_detect.sv */
// hit_detect module, box overlap test between barrel and player
`default_nettype none

module hit_detect import fall_pkg::*; (
    input  pos_t barrel,
    input  pos_t player,
    output logic hit
);

    // right and bottom edges, widened so sums near the screen edge do not wrap
    logic [11:0] barrel_right;
    logic [11:0] barrel_bottom;
    logic [11:0] player_right;
    logic [11:0] player_bottom;

    logic overlap_x;
    logic overlap_y;

    assign barrel_right  = {1'b0, barrel.x} + {1'b0, BARREL_W};
    assign barrel_bottom = {1'b0, barrel.y} + {1'b0, BARREL_H};
    assign player_right  = {1'b0, player.x} + {1'b0, PLAYER_W};
    assign player_bottom = {1'b0, player.y} + {1'b0, PLAYER_H};

    // boxes touching edge to edge do not count as a hit
    assign overlap_x = ({1'b0, barrel.x} < player_right) &&
                       ({1'b0, player.x} < barrel_right);
    assign overlap_y = ({1'b0, barrel.y} < player_bottom) &&
                       ({1'b0, player.y} < barrel_bottom);

    assign hit = overlap_x && overlap_y;

endmodule

`default_nettype wire

/* design/barrel_ctrl.sv */
// barrel_ctrl module, FSM for spawn acceptance, fall supervision and result hand-off
`default_nettype none

module barrel_ctrl import fall_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         spawn_valid,
    output logic         spawn_ready,
    input  logic         hit,
    input  logic         at_floor,
    input  pos_t         pos,
    output logic         load,
    output logic         run,
    output logic         barrel_active,
    output logic         result_valid,
    input  logic         result_ready,
    output fall_result_t result
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FALLING,
        ST_REPORTING
    } state_t;

    state_t state;
    state_t state_nxt;

    logic spawn_fire;
    logic result_fire;
    logic fall_done;

    assign spawn_fire  = spawn_valid && spawn_ready;
    assign result_fire = result_valid && result_ready;
    assign fall_done   = (state == ST_FALLING) && (hit || at_floor);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (spawn_fire) begin
                    state_nxt = ST_FALLING;
                end
            end

            ST_FALLING: begin
                if (fall_done) begin
                    state_nxt = ST_REPORTING;
                end
            end

            ST_REPORTING: begin
                if (result_fire) begin
                    state_nxt = ST_IDLE;   // spawn_ready comes back next cycle
                end
            end

            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // result is captured from the position that ended the fall
    always_ff @(posedge clk) begin
        if (fall_done) begin
            result.hit     <= hit;
            result.end_pos <= pos;
        end
    end

    assign spawn_ready = (state == ST_IDLE);

    // motion loads its start position on the accepting edge
    assign load = spawn_fire;

    assign run           = (state == ST_FALLING);
    assign barrel_active = (state == ST_FALLING);
    assign result_valid  = (state == ST_REPORTING);

endmodule

`default_nettype wire

/* design/barrel_drop_top.sv */
// barrel_drop_top module, falling barrel subsystem with controller, step timer, motion and hit test
`default_nettype none

module barrel_drop_top import fall_pkg::*; #(
    parameter int unsigned STEP_PERIOD = 20000
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         spawn_valid,
    output logic         spawn_ready,
    input  coord_t       kong_x,
    input  pos_t         player_pos,
    output logic         result_valid,
    input  logic         result_ready,
    output fall_result_t result,
    output pos_t         barrel_pos,
    output logic         barrel_active
);

    logic load;
    logic run;
    logic step;
    logic at_floor;
    logic hit;
    pos_t pos;

    barrel_ctrl i_barrel_ctrl (
        .clk           (clk),
        .rst           (rst),
        .spawn_valid   (spawn_valid),
        .spawn_ready   (spawn_ready),
        .hit           (hit),
        .at_floor      (at_floor),
        .pos           (pos),
        .load          (load),
        .run           (run),
        .barrel_active (barrel_active),
        .result_valid  (result_valid),
        .result_ready  (result_ready),
        .result        (result)
    );

    step_timer #(
        .STEP_PERIOD (STEP_PERIOD)
    ) i_step_timer (
        .clk  (clk),
        .rst  (rst),
        .run  (run),
        .step (step)
    );

    barrel_motion i_barrel_motion (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .kong_x   (kong_x),
        .step     (step),
        .pos      (pos),
        .at_floor (at_floor)
    );

    hit_detect i_hit_detect (
        .barrel (pos),
        .player (player_pos),
        .hit    (hit)
    );

    assign barrel_pos = pos;   // renderer follows the live position

endmodule

`default_nettype wire

/* sim/barrel_drop_tb.sv */
// barrel_drop_tb module, directed tests with a fall reference model, LCG stimulus and timeout
`default_nettype none

module barrel_drop_tb import fall_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned STEP_PERIOD = 3;
    localparam int TIMEOUT_CYCLES = 4000;   // about 11 falls of up to 145 cycles, wide margin
    localparam int RANDOM_FALLS = 6;

    logic         clk;
    logic         rst;
    logic         spawn_valid;
    logic         spawn_ready;
    coord_t       kong_x;
    pos_t         player_pos;
    logic         result_valid;
    logic         result_ready;
    fall_result_t result;
    pos_t         barrel_pos;
    logic         barrel_active;

    int          error_count;
    int          fall_count;
    int          cycle_count = 0;
    logic [31:0] lcg_state;

    barrel_drop_top #(
        .STEP_PERIOD (STEP_PERIOD)
    ) i_barrel_drop_top (
        .clk           (clk),
        .rst           (rst),
        .spawn_valid   (spawn_valid),
        .spawn_ready   (spawn_ready),
        .kong_x        (kong_x),
        .player_pos    (player_pos),
        .result_valid  (result_valid),
        .result_ready  (result_ready),
        .result        (result),
        .barrel_pos    (barrel_pos),
        .barrel_active (barrel_active)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;   // 20 ns period

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a fall or handshake never finished", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'd0, lcg_state[31:16]};   // upper bits are the better ones
    endfunction

    function automatic pos_t make_pos(input int x, input int y);
        pos_t p;
        p.x = coord_t'(x);
        p.y = coord_t'(y);
        return p;
    endfunction

    // edge to edge contact is not an overlap
    function automatic bit boxes_overlap(input pos_t barrel, input pos_t player);
        int bx;
        int by;
        int px;
        int py;
        bx = int'(barrel.x);
        by = int'(barrel.y);
        px = int'(player.x);
        py = int'(player.y);
        return (bx < px + int'(PLAYER_W)) && (px < bx + int'(BARREL_W)) &&
               (by < py + int'(PLAYER_H)) && (py < by + int'(BARREL_H));
    endfunction

    // y after n gravity steps from the start row
    function automatic int y_after_steps(input int n);
        int y;
        int v;
        y = int'(PLATFORM_Y) + 64;
        v = 0;
        for (int i = 0; i < n; i++) begin
            y = y + v;
            if (y > int'(FLOOR_Y)) begin
                y = int'(FLOOR_Y);
            end
            v = v + 1;
        end
        return y;
    endfunction

    function automatic fall_result_t model_fall(input coord_t kx, input pos_t player);
        fall_result_t res;
        pos_t         p;
        p.x = kx + SPAWN_X_OFFSET;
        res = '0;
        for (int n = 0; n < 64; n++) begin
            p.y = coord_t'(y_after_steps(n));
            if (boxes_overlap(p, player) || p.y == FLOOR_Y) begin
                res.hit = boxes_overlap(p, player);
                res.end_pos = p;
                return res;
            end
        end
        return res;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        error_count++;
        $display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
    endtask

    task automatic check_result(input fall_result_t expected, input fall_result_t got);
        if (got.hit != expected.hit) begin
            report_mismatch("result.hit", expected.hit, got.hit);
        end
        if (got.end_pos.x != expected.end_pos.x) begin
            report_mismatch("result.end_pos.x", expected.end_pos.x, got.end_pos.x);
        end
        if (got.end_pos.y != expected.end_pos.y) begin
            report_mismatch("result.end_pos.y", expected.end_pos.y, got.end_pos.y);
        end
    endtask

    // returns on the falling edge right after the accepting edge
    task automatic do_spawn(input coord_t kx, input pos_t player);
        @(negedge clk);
        kong_x = kx;
        player_pos = player;
        spawn_valid = 1'b1;
        while (!spawn_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        @(negedge clk);
        spawn_valid = 1'b0;
    endtask

    task automatic take_result(output fall_result_t got);
        @(negedge clk);
        result_ready = 1'b1;
        while (!result_valid) begin
            @(negedge clk);
        end
        got = result;
        @(posedge clk);   // transfer edge
        @(negedge clk);
        result_ready = 1'b0;
        fall_count++;
        if (spawn_ready !== 1'b1) begin
            report_mismatch("spawn_ready", 1, spawn_ready);
        end
    endtask

    task automatic run_fall(input coord_t kx, input pos_t player);
        fall_result_t got;
        do_spawn(kx, player);
        take_result(got);
        check_result(model_fall(kx, player), got);
    endtask

    task automatic reset_state();
        if (spawn_ready !== 1'b1) begin
            report_mismatch("spawn_ready", 1, spawn_ready);
        end
        if (result_valid !== 1'b0) begin
            report_mismatch("result_valid", 0, result_valid);
        end
        if (barrel_active !== 1'b0) begin
            report_mismatch("barrel_active", 0, barrel_active);
        end
    endtask

    task automatic miss_fall();
        fall_result_t got;
        fall_result_t expected;
        expected.hit = 1'b0;
        expected.end_pos = make_pos(300 + 12, int'(FLOOR_Y));
        do_spawn(11'd300, make_pos(900, 600));
        take_result(got);
        check_result(expected, got);
    endtask

    task automatic step_sequence();
        fall_result_t got;
        int           k;
        do_spawn(11'd40, make_pos(1000, 100));
        if (barrel_pos.x != 11'd52) begin
            report_mismatch("barrel_pos.x at start", 52, barrel_pos.x);
        end
        if (barrel_pos.y != 11'd164) begin
            report_mismatch("barrel_pos.y at start", 164, barrel_pos.y);
        end
        if (barrel_active !== 1'b1) begin
            report_mismatch("barrel_active", 1, barrel_active);
        end
        repeat (5) @(negedge clk);
        k = 1;
        while (1) begin
            if (int'(barrel_pos.y) != y_after_steps(k)) begin
                report_mismatch("barrel_pos.y", y_after_steps(k), barrel_pos.y);
            end
            if (y_after_steps(k) == int'(FLOOR_Y) || k > 60) begin
                break;
            end
            k++;
            repeat (4) @(negedge clk);
        end
        take_result(got);
        check_result(model_fall(11'd40, make_pos(1000, 100)), got);
    endtask

    task automatic hit_fall();
        fall_result_t expected;
        expected = model_fall(11'd200, make_pos(220, 400));
        if (!expected.hit) begin
            error_count++;
            $display("hit test setup does not place the player in the barrel's path");
        end
        run_fall(11'd200, make_pos(220, 400));
    endtask

    task automatic back_pressure();
        fall_result_t held;
        fall_result_t got;
        do_spawn(11'd500, make_pos(0, 0));
        while (!result_valid) begin
            @(negedge clk);
        end
        held = result;
        spawn_valid = 1'b1;   // offered while the result is still pending
        kong_x = 11'd100;
        player_pos = make_pos(130, 300);
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            if (result_valid !== 1'b1) begin
                report_mismatch("result_valid", 1, result_valid);
            end
            if (result != held) begin
                report_mismatch("result", int'(held), int'(result));
            end
            if (spawn_ready !== 1'b0) begin
                report_mismatch("spawn_ready", 0, spawn_ready);
            end
            if (barrel_active !== 1'b0) begin
                report_mismatch("barrel_active", 0, barrel_active);
            end
        end
        result_ready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        result_ready = 1'b0;
        fall_count++;
        check_result(model_fall(11'd500, make_pos(0, 0)), held);
        if (result_valid !== 1'b0) begin
            report_mismatch("result_valid", 0, result_valid);
        end
        if (spawn_ready !== 1'b1) begin
            report_mismatch("spawn_ready", 1, spawn_ready);
        end
        @(posedge clk);   // the waiting spawn is taken here
        @(negedge clk);
        spawn_valid = 1'b0;
        if (barrel_active !== 1'b1) begin
            report_mismatch("barrel_active", 1, barrel_active);
        end
        take_result(got);
        check_result(model_fall(11'd100, make_pos(130, 300)), got);
    endtask

    task automatic random_falls();
        coord_t kx;
        int     px;
        int     py;
        for (int i = 0; i < RANDOM_FALLS; i++) begin
            kx = coord_t'(next_rand() % 900);
            px = int'(kx) + 12 + int'(next_rand() % 96) - 48;   // near the barrel column
            if (px < 0) begin
                px = 0;
            end
            py = 200 + int'(next_rand() % 520);
            run_fall(kx, make_pos(px, py));
        end
    endtask

    initial begin
        lcg_state = 32'd29;
        error_count = 0;
        fall_count = 0;
        rst = 1'b1;
        spawn_valid = 1'b0;
        kong_x = '0;
        player_pos = '0;
        result_ready = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_state();
        miss_fall();
        step_sequence();
        hit_fall();
        back_pressure();
        random_falls();

        $display("falls checked: %0d, errors: %0d", fall_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
design/fall_pkg.sv
design/step_timer.sv
design/barrel_motion.sv
design/hit_detect.sv
design/barrel_ctrl.sv
design/barrel_drop_top.sv
sim/barrel_drop_tb.sv

/* Bender.yml */
package:
  name: barrel_drop
  description: "Falling barrel subsystem for a VGA platform game"

sources:
  # package first, then leaf modules, then the top level
  - files:
      - design/fall_pkg.sv
      - design/step_timer.sv
      - design/barrel_motion.sv
      - design/hit_detect.sv
      - design/barrel_ctrl.sv
      - design/barrel_drop_top.sv

  # directed testbench, only for simulation
  - target: simulation
    files:
      - sim/barrel_drop_tb.sv

# top modules
#   RTL:        barrel_drop_top
#   simulation: barrel_drop_tb
